// File: Makefile
TOP = tb_msg_loop

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "sim passed" sim.log

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: test/tb_msg_loop.sv
`timescale 1ns/100ps

module tb_msg_loop;
	import msg_pkg::*;
	import dbg_pkg::*;

	localparam int DRAIN = 40;
	localparam int TIMEOUT = 500;

	typedef struct packed {
		logic rst;
		logic chk;
		logic bad;
		addr_t src;
		addr_t dst;
		data_t dat;
		led_t leds;
		disp_t d0;
		disp_t d1;
	} entry_t;

	logic snk_clk;
	logic arst_n;
	logic run;
	logic in_req;
	logic in_ack;
	addr_t in_src;
	addr_t in_dst;
	data_t in_dat;
	redun_t in_red;
	led_t leds;
	disp_t disp0;
	disp_t disp1;
	integer seed;
	entry_t table_q[$];

	msg_loop_top #(
		.MIN_ADDR(1),
		.MAX_ADDR(3),
		.DEPTH(4)
	) msg_loop_top_inst (
		.snk_clk(snk_clk),
		.arst_n(arst_n),
		.run(run),
		.in_req(in_req),
		.in_ack(in_ack),
		.in_src(in_src),
		.in_dst(in_dst),
		.in_dat(in_dat),
		.in_red(in_red),
		.leds(leds),
		.disp0(disp0),
		.disp1(disp1)
	);

	always #10 snk_clk = ~snk_clk;

	task automatic report_fail(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic add_entry(input logic rst, input logic chk, input logic bad,
		input addr_t src, input addr_t dst, input data_t dat,
		input led_t x_leds, input disp_t x_d0, input disp_t x_d1);
		entry_t e;
		e = '{rst, chk, bad, src, dst, dat, x_leds, x_d0, x_d1};
		table_q.push_back(e);
	endtask

	task automatic build_table();
		int i;
		// Source 1 counts through 15 and wraps to 0
		for (i = 0; i < 17; i++) begin
			add_entry(1'b0, 1'b1, 1'b0, 4'd1, 4'd0, data_t'(i % 16), '0, '0, '0);
		end
		// Bad red, then more faults on a sticky bit
		add_entry(1'b0, 1'b1, 1'b1, 4'd1, 4'd2, 8'd1, led_t'(1 << LED_SRC1), '0, '0);
		add_entry(1'b0, 1'b1, 1'b1, 4'd1, 4'd5, 8'd9, led_t'(1 << LED_SRC1), '0, '0);
		add_entry(1'b0, 1'b1, 1'b0, 4'd1, 4'd0, 8'd7, led_t'(1 << LED_SRC1), '0, '0);
		// Gap from 3 to 5
		add_entry(1'b1, 1'b1, 1'b0, 4'd1, 4'd0, 8'd3, '0, '0, '0);
		add_entry(1'b0, 1'b1, 1'b0, 4'd1, 4'd0, 8'd5, led_t'(1 << LED_SRC1), 4'd5, 4'd3);
		// Out of range, prev1 still at the top of the sequence
		add_entry(1'b1, 1'b1, 1'b0, 4'd1, 4'd0, 8'd20, led_t'(1 << LED_RANGE), '0, '0);
		// Back to back bursts that fill the queue
		for (i = 0; i < 16; i++) begin
			add_entry(i == 0, i == 15, 1'b0, 4'd1, 4'd0, data_t'(i), '0, '0, '0);
			if (i % 2 == 0) begin
				add_entry(1'b0, 1'b0, 1'b1, addr_t'(2 + (i / 2) % 2), 4'd1, data_t'(i),
					'0, '0, '0);
			end
		end
	endtask

	task automatic check_status(input led_t x_leds, input disp_t x_d0, input disp_t x_d1);
		assert (leds == x_leds) else report_fail($sformatf(
			"MISMATCH time=%0t signal=leds expected=%h actual=%h", $time, x_leds, leds));
		assert (disp0 == x_d0) else report_fail($sformatf(
			"MISMATCH time=%0t signal=disp0 expected=%h actual=%h", $time, x_d0, disp0));
		assert (disp1 == x_d1) else report_fail($sformatf(
			"MISMATCH time=%0t signal=disp1 expected=%h actual=%h", $time, x_d1, disp1));
	endtask

	// Status must read zero right after reset
	task automatic apply_reset();
		@(posedge snk_clk);
		in_req <= 1'b0;
		arst_n <= 1'b0;
		repeat (8) @(posedge snk_clk);
		arst_n <= 1'b1;
		@(negedge snk_clk);
		check_status('0, '0, '0);
	endtask

	task automatic send_msg(input addr_t src, input addr_t dst, input data_t dat,
		input logic bad);
		int n;
		@(posedge snk_clk);
		in_src <= src;
		in_dst <= dst;
		in_dat <= dat;
		in_red <= calc_redun(src, dst, dat) ^ redun_t'(bad);
		in_req <= 1'b1;
		n = 0;
		@(negedge snk_clk);
		while (!in_ack) begin
			if (n == TIMEOUT) report_fail("timeout waiting for in_ack to rise");
			n++;
			@(negedge snk_clk);
		end
		@(posedge snk_clk);
		in_req <= 1'b0;
		n = 0;
		@(negedge snk_clk);
		while (in_ack) begin
			if (n == TIMEOUT) report_fail("timeout waiting for in_ack to fall");
			n++;
			@(negedge snk_clk);
		end
	endtask

	initial begin
		entry_t e;
		addr_t dst;
		snk_clk = 1'b0;
		arst_n = 1'b0;
		run = 1'b1;
		in_req = 1'b0;
		in_src = '0;
		in_dst = '0;
		in_dat = '0;
		in_red = '0;
		seed = 32'h80e2_f4ac;
		build_table();
		apply_reset();
		foreach (table_q[n]) begin
			e = table_q[n];
			if (e.rst) apply_reset();
			dst = e.dst;
			// Clean source 1 traffic goes to random nodes
			if ((e.src == 4'd1) && !e.bad) dst = addr_t'($random(seed));
			send_msg(e.src, dst, e.dat, e.bad);
			if (e.chk) begin
				repeat (DRAIN) @(posedge snk_clk);
				@(negedge snk_clk);
				check_status(e.leds, e.d0, e.d1);
			end
		end
		$display("sim passed");
		$finish;
	end

endmodule

// File: verilog.f
verilog/msg_pkg.sv
verilog/dbg_pkg.sv
verilog/msg_chnl_if.sv
verilog/msg_source.sv
verilog/msg_fifo.sv
verilog/msg_checker.sv
verilog/msg_loop_top.sv
test/tb_msg_loop.sv

// File: verilog/dbg_pkg.sv
package dbg_pkg;

	typedef logic [3:0] led_t;
	typedef logic [3:0] disp_t;

	// Bit positions in led_t
	localparam int LED_SRC0 = 0;
	localparam int LED_SRC1 = 1;
	localparam int LED_RANGE = 2;
	localparam int LED_GEN = 3;

endpackage

// File: verilog/msg_checker.sv
`timescale 1ns/100ps

module msg_checker (
	input logic snk_clk,
	input logic arst_n,
	msg_chnl_if.acceptor ch,
	input logic gen_err,
	output dbg_pkg::led_t leds,
	output dbg_pkg::disp_t disp0,
	output dbg_pkg::disp_t disp1
);
	import msg_pkg::*;
	import dbg_pkg::*;

	typedef enum logic [1:0] {
		C_IDLE,
		C_CHECK,
		C_ACK
	} chk_state_t;

	chk_state_t state;
	logic ack_r;
	data_t prev0;
	data_t prev1;
	data_t prev_sel;
	logic known;
	logic sel;
	logic [1:0] fault_bit;
	logic src_fault;
	logic red_bad;
	logic seq_bad;
	led_t led_r;
	disp_t d0_r;
	disp_t d1_r;

	// Only sources 0 and 1 are tracked
	assign known = (ch.src < addr_t'(2));
	assign sel = ch.src[0];
	assign prev_sel = sel ? prev1 : prev0;
	assign fault_bit = sel ? 2'(LED_SRC1) : 2'(LED_SRC0);
	assign src_fault = led_r[fault_bit];

	assign red_bad = (ch.red != calc_redun(ch.src, ch.dst, ch.dat));
	// After the top of the sequence any value restarts it
	assign seq_bad = (prev_sel <= data_t'(SEQ_MAX - 1)) && (ch.dat != prev_sel + 1'b1);

	always_ff @(posedge snk_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= C_IDLE;
			ack_r <= 1'b0;
			prev0 <= data_t'(SEQ_MAX);
			prev1 <= data_t'(SEQ_MAX);
			led_r <= '0;
			d0_r <= '0;
			d1_r <= '0;
		end else begin
			led_r[LED_GEN] <= gen_err;
			case (state)
				C_IDLE: begin
					if (ch.req) begin
						if (ch.dat > SEQ_MAX) begin
							led_r[LED_RANGE] <= 1'b1;
						end
						// A faulted source is no longer checked
						if (known && !src_fault) begin
							if (red_bad) begin
								led_r[fault_bit] <= 1'b1;
							end else if (seq_bad) begin
								led_r[fault_bit] <= 1'b1;
								d0_r <= disp_t'(ch.dat);
								d1_r <= disp_t'(prev_sel);
							end else if (sel) begin
								prev1 <= ch.dat;
							end else begin
								prev0 <= ch.dat;
							end
						end
						state <= C_CHECK;
					end
				end
				C_CHECK: begin
					ack_r <= 1'b1;
					state <= C_ACK;
				end
				C_ACK: begin
					if (!ch.req) begin
						ack_r <= 1'b0;
						state <= C_IDLE;
					end
				end
				default: begin
					state <= C_IDLE;
				end
			endcase
		end
	end

	// Display stage
	always_ff @(posedge snk_clk or negedge arst_n) begin
		if (!arst_n) begin
			leds <= '0;
			disp0 <= '0;
			disp1 <= '0;
		end else begin
			leds <= led_r;
			disp0 <= d0_r;
			disp1 <= d1_r;
		end
	end

	assign ch.ack = ack_r;

endmodule

// File: verilog/msg_chnl_if.sv
`timescale 1ns/100ps

interface msg_chnl_if;
	import msg_pkg::*;

	logic req;
	logic ack;
	addr_t src;
	addr_t dst;
	data_t dat;
	redun_t red;

	// Four-phase side that owns the message
	modport requester (
		output req,
		output src,
		output dst,
		output dat,
		output red,
		input ack
	);

	modport acceptor (
		input req,
		input src,
		input dst,
		input dat,
		input red,
		output ack
	);

endinterface

// File: verilog/msg_fifo.sv
`timescale 1ns/100ps

module msg_fifo #(
	parameter int DEPTH = 4
) (
	input logic snk_clk,
	input logic arst_n,
	msg_chnl_if.acceptor a,
	input logic in_req,
	output logic in_ack,
	input msg_pkg::addr_t in_src,
	input msg_pkg::addr_t in_dst,
	input msg_pkg::data_t in_dat,
	input msg_pkg::redun_t in_red,
	msg_chnl_if.requester q
);
	import msg_pkg::*;

	localparam int PW = $clog2(DEPTH);

	addr_t src_mem [DEPTH];
	addr_t dst_mem [DEPTH];
	data_t dat_mem [DEPTH];
	redun_t red_mem [DEPTH];

	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [PW:0] count;
	logic full;
	logic ack_a;
	logic ack_b;
	logic pend_a;
	logic pend_b;
	logic prio_b;
	logic grant_a;
	logic grant_b;
	logic push;
	logic pop;
	logic req_q;
	logic drain;

	assign full = (count == (PW+1)'(DEPTH));

	// A new request is one not yet acknowledged
	assign pend_a = a.req && !ack_a;
	assign pend_b = in_req && !ack_b;

	// Round robin when both inputs wait, ack withheld while full
	assign grant_a = pend_a && !full && (!pend_b || !prio_b);
	assign grant_b = pend_b && !full && !grant_a;
	assign push = grant_a || grant_b;

	// Head leaves once the consumer has dropped ack
	assign pop = drain && !q.ack;

	always_ff @(posedge snk_clk or negedge arst_n) begin
		if (!arst_n) begin
			ack_a <= 1'b0;
			ack_b <= 1'b0;
			prio_b <= 1'b0;
		end else begin
			if (grant_a) begin
				ack_a <= 1'b1;
			end else if (!a.req) begin
				ack_a <= 1'b0;
			end
			if (grant_b) begin
				ack_b <= 1'b1;
			end else if (!in_req) begin
				ack_b <= 1'b0;
			end
			if (push) begin
				prio_b <= grant_a;
			end
		end
	end

	always_ff @(posedge snk_clk) begin
		if (push) begin
			src_mem[wr_ptr] <= grant_a ? a.src : in_src;
			dst_mem[wr_ptr] <= grant_a ? a.dst : in_dst;
			dat_mem[wr_ptr] <= grant_a ? a.dat : in_dat;
			red_mem[wr_ptr] <= grant_a ? a.red : in_red;
		end
	end

	always_ff @(posedge snk_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + (PW+1)'(push) - (PW+1)'(pop);
		end
	end

	// Output engine
	always_ff @(posedge snk_clk or negedge arst_n) begin
		if (!arst_n) begin
			req_q <= 1'b0;
			drain <= 1'b0;
		end else begin
			if (req_q) begin
				if (q.ack) begin
					req_q <= 1'b0;
					drain <= 1'b1;
				end
			end else if (drain) begin
				if (!q.ack) begin
					drain <= 1'b0;
				end
			end else if ((count != '0) && !q.ack) begin
				req_q <= 1'b1;
			end
		end
	end

	assign a.ack = ack_a;
	assign in_ack = ack_b;

	assign q.req = req_q;
	assign q.src = src_mem[rd_ptr];
	assign q.dst = dst_mem[rd_ptr];
	assign q.dat = dat_mem[rd_ptr];
	assign q.red = red_mem[rd_ptr];

endmodule

// File: verilog/msg_loop_top.sv
`timescale 1ns/100ps

module msg_loop_top #(
	parameter int MIN_ADDR = 1,
	parameter int MAX_ADDR = 3,
	parameter int DEPTH = 4
) (
	input logic snk_clk,
	input logic arst_n,
	input logic run,
	input logic in_req,
	output logic in_ack,
	input msg_pkg::addr_t in_src,
	input msg_pkg::addr_t in_dst,
	input msg_pkg::data_t in_dat,
	input msg_pkg::redun_t in_red,
	output dbg_pkg::led_t leds,
	output dbg_pkg::disp_t disp0,
	output dbg_pkg::disp_t disp1
);

	logic gen_err;

	msg_chnl_if gen_ch ();
	msg_chnl_if out_ch ();

	// Counting traffic as source 0
	msg_source #(
		.MIN_ADDR(MIN_ADDR),
		.MAX_ADDR(MAX_ADDR)
	) msg_source_inst (
		.snk_clk(snk_clk),
		.arst_n(arst_n),
		.run(run),
		.gen_err(gen_err),
		.ch(gen_ch.requester)
	);

	// Merges source 0 with the external channel
	msg_fifo #(
		.DEPTH(DEPTH)
	) msg_fifo_inst (
		.snk_clk(snk_clk),
		.arst_n(arst_n),
		.a(gen_ch.acceptor),
		.in_req(in_req),
		.in_ack(in_ack),
		.in_src(in_src),
		.in_dst(in_dst),
		.in_dat(in_dat),
		.in_red(in_red),
		.q(out_ch.requester)
	);

	msg_checker msg_checker_inst (
		.snk_clk(snk_clk),
		.arst_n(arst_n),
		.ch(out_ch.acceptor),
		.gen_err(gen_err),
		.leds(leds),
		.disp0(disp0),
		.disp1(disp1)
	);

endmodule

// File: verilog/msg_pkg.sv
package msg_pkg;

	// Field widths
	localparam int ASZ = 4;
	localparam int DSZ = 8;
	localparam int RSZ = 4;

	// Top of the counting sequence, also the valid data limit
	localparam int SEQ_MAX = 15;

	typedef logic [ASZ-1:0] addr_t;
	typedef logic [DSZ-1:0] data_t;
	typedef logic [RSZ-1:0] redun_t;

	// Low bits of the unsigned sum of all fields
	function automatic redun_t calc_redun(
		input addr_t src,
		input addr_t dst,
		input data_t dat
	);
		logic [DSZ+1:0] sum;
		sum = {2'b00, dat};
		sum = sum + {{(DSZ-ASZ+2){1'b0}}, src};
		sum = sum + {{(DSZ-ASZ+2){1'b0}}, dst};
		return sum[RSZ-1:0];
	endfunction

endpackage

// File: verilog/msg_source.sv
`timescale 1ns/100ps

module msg_source #(
	parameter int MIN_ADDR = 1,
	parameter int MAX_ADDR = 3
) (
	input logic snk_clk,
	input logic arst_n,
	input logic run,
	output logic gen_err,
	msg_chnl_if.requester ch
);
	import msg_pkg::*;

	typedef enum logic [1:0] {
		S_LOAD,
		S_REQUEST,
		S_RELEASE
	} src_state_t;

	localparam addr_t SRC_ID = '0;

	src_state_t state;
	logic load;
	logic req_r;
	data_t cnt;
	addr_t dst_r;
	data_t dat_r;
	redun_t red_r;

	// Build the next message once the channel is quiet
	assign load = run && ((state == S_LOAD) || ((state == S_RELEASE) && !ch.ack));

	always_ff @(posedge snk_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_LOAD;
			req_r <= 1'b0;
		end else begin
			case (state)
				S_LOAD: begin
					if (load) begin
						state <= S_REQUEST;
					end
				end
				S_REQUEST: begin
					if (!req_r) begin
						req_r <= 1'b1;
					end else if (ch.ack) begin
						req_r <= 1'b0;
						state <= S_RELEASE;
					end
				end
				S_RELEASE: begin
					if (!ch.ack) begin
						state <= load ? S_REQUEST : S_LOAD;
					end
				end
				default: begin
					state <= S_LOAD;
				end
			endcase
		end
	end

	always_ff @(posedge snk_clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			dst_r <= addr_t'(MIN_ADDR);
			dat_r <= '0;
			red_r <= '0;
			gen_err <= 1'b0;
		end else begin
			if (load) begin
				dat_r <= cnt;
				red_r <= calc_redun(SRC_ID, dst_r, cnt);
				cnt <= (cnt >= SEQ_MAX) ? '0 : cnt + 1'b1;
			end
			// Next destination as req falls
			if ((state == S_REQUEST) && req_r && ch.ack) begin
				dst_r <= (dst_r >= MAX_ADDR) ? addr_t'(MIN_ADDR) : dst_r + 1'b1;
			end
			// Sticky, data register out of range
			if (dat_r > SEQ_MAX) begin
				gen_err <= 1'b1;
			end
		end
	end

	assign ch.req = req_r;
	assign ch.src = SRC_ID;
	assign ch.dst = dst_r;
	assign ch.dat = dat_r;
	assign ch.red = red_r;

endmodule
